// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk64,
   output logic rx_dsp_reset
);

   initial begin
      clk64 = 1'b0;
      forever #(PERIOD_NS / 2) clk64 = ~clk64;
   end

   // Reset drops just after the last reset edge, like any other input
   initial begin
      rx_dsp_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk64);
      #1;
      rx_dsp_reset = 1'b0;
   end

endmodule

// File: dv/tb_usrp_dsp.sv
`timescale 1ns/1ps

module tb_usrp_dsp;

   localparam int          CLK_PERIOD_NS  = 100;
   localparam int          RESET_CYCLES   = 4;
   localparam int          DRIVE_DELAY_NS = 1;
   localparam int          TIMEOUT_FACTOR = 2;
   localparam logic [31:0] LCG_SEED       = 32'hef4812a8;
   localparam int          NUM_TESTS      = 14;

   typedef enum {
      CHK_RESET, CHK_TXSYNC, CHK_DAC, CHK_INTERP, CHK_DECIM,
      CHK_NO_HB, CHK_LOOPBACK, CHK_COUNT_IDLE, CHK_COUNT_RUN
   } check_e;

   // Expected is a period in cycles, or a count of cycles or pulses to check
   typedef struct {
      string                   name;
      usrp_pkg::serial_addr_t  addr;
      usrp_pkg::serial_data_t  data;
      check_e                  kind;
      int                      expected;
      int                      budget;
   } test_entry_t;

   logic                    clk64;
   logic                    rx_dsp_reset;
   logic                    serial_strobe;
   usrp_pkg::serial_addr_t  serial_addr;
   usrp_pkg::serial_data_t  serial_data;
   // TX inputs in order i0, q0, i1, q1
   usrp_pkg::sample_t       tx_in [4];
   usrp_pkg::sample_t       rx_i0;
   usrp_pkg::sample_t       rx_q0;
   usrp_pkg::dac_word_t     tx_a;
   usrp_pkg::dac_word_t     tx_b;
   logic                    txsync;
   logic                    strobe_interp;
   logic                    hb_strobe;
   usrp_pkg::sample_t       rx_ch0;
   usrp_pkg::sample_t       rx_ch1;

   test_entry_t             test_table [NUM_TESTS];
   usrp_pkg::dac_src_e      mux_model [usrp_pkg::NUM_DAC];
   logic [31:0]             lcg_state = LCG_SEED;
   logic                    table_ready = 1'b0;
   int                      test_errors;
   int                      pass_count;
   int                      fail_count;

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD_NS),
      .RESET_CYCLES (RESET_CYCLES)
   ) u_clock_gen (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset)
   );

   usrp_dsp_top u_dut (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (serial_strobe),
      .i_serial_addr   (serial_addr),
      .i_serial_data   (serial_data),
      .i_tx_i0         (tx_in[0]),
      .i_tx_q0         (tx_in[1]),
      .i_tx_i1         (tx_in[2]),
      .i_tx_q1         (tx_in[3]),
      .i_rx_i0         (rx_i0),
      .i_rx_q0         (rx_q0),
      .o_tx_a          (tx_a),
      .o_tx_b          (tx_b),
      .o_txsync        (txsync),
      .o_strobe_interp (strobe_interp),
      .o_hb_strobe     (hb_strobe),
      .o_rx_ch0        (rx_ch0),
      .o_rx_ch1        (rx_ch1)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table

   function automatic void build_table();
      test_table[0]  = '{"reset_state", usrp_pkg::FR_MASTER_CTRL, 32'h0, CHK_RESET, 4, 8};
      // TX on
      test_table[1]  = '{"tx_enable", usrp_pkg::FR_MASTER_CTRL, 32'h1, CHK_TXSYNC, 6, 8};
      test_table[2]  = '{"dac_interleave", usrp_pkg::FR_TX_MUX, 32'h0, CHK_DAC, 8, 14};
      test_table[3]  = '{"interp_rate_0", usrp_pkg::FR_INTERP_RATE, 32'd0, CHK_INTERP, 2, 10};
      test_table[4]  = '{"interp_rate_3", usrp_pkg::FR_INTERP_RATE, 32'd3, CHK_INTERP, 8, 28};
      test_table[5]  = '{"interp_rate_7", usrp_pkg::FR_INTERP_RATE, 32'd7, CHK_INTERP, 16, 52};
      // TX and RX on, decimation rate still 0
      test_table[6]  = '{"rx_enable", usrp_pkg::FR_MASTER_CTRL, 32'h3, CHK_DECIM, 1, 10};
      test_table[7]  = '{"decim_rate_1", usrp_pkg::FR_DECIM_RATE, 32'd1, CHK_DECIM, 2, 10};
      test_table[8]  = '{"decim_rate_5", usrp_pkg::FR_DECIM_RATE, 32'd5, CHK_DECIM, 6, 22};
      test_table[9]  = '{"rx_disable_quiet", usrp_pkg::FR_MASTER_CTRL, 32'h1, CHK_NO_HB, 20, 24};
      // Mode word, bit 0 loopback and bit 1 counter
      test_table[10] = '{"loopback", usrp_pkg::FR_MODE, 32'h1, CHK_LOOPBACK, 0, 24};
      test_table[11] = '{"counter_idle", usrp_pkg::FR_MODE, 32'h3, CHK_COUNT_IDLE, 0, 6};
      test_table[12] = '{"counter_run", usrp_pkg::FR_MASTER_CTRL, 32'h3, CHK_COUNT_RUN, 4, 34};
      test_table[13] = '{"counter_clear", usrp_pkg::FR_MASTER_CTRL, 32'h1, CHK_COUNT_IDLE, 0, 6};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Random numbers and expected values

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic usrp_pkg::sample_t random_sample();
      logic [31:0] r;
      r = lcg_next();
      return r[31:16];
   endfunction

   function automatic usrp_pkg::dac_src_e random_code();
      logic [31:0] r;
      r = lcg_next();
      case (r[31:16] % 16'd5)
         16'd0:   return usrp_pkg::DAC_ZERO;
         16'd1:   return usrp_pkg::DAC_I0;
         16'd2:   return usrp_pkg::DAC_Q0;
         16'd3:   return usrp_pkg::DAC_I1;
         default: return usrp_pkg::DAC_Q1;
      endcase
   endfunction

   // One slot is always forced to zero
   function automatic usrp_pkg::serial_data_t random_mux_word();
      usrp_pkg::serial_data_t word;
      logic [31:0]            r;
      int                     zero_slot;
      word = '0;
      r = lcg_next();
      zero_slot = int'(r[17:16]);
      for (int k = 0; k < usrp_pkg::NUM_DAC; k++) begin
         mux_model[k] = (k == zero_slot) ? usrp_pkg::DAC_ZERO : random_code();
         word[usrp_pkg::TX_MUX_DAC0_LSB + 4*k +: 4] = mux_model[k];
      end
      return word;
   endfunction

   // Index into tx_in is {chain, Q}
   function automatic usrp_pkg::dac_word_t expected_dac(input usrp_pkg::dac_src_e code);
      logic [3:0]        bits;
      usrp_pkg::sample_t chosen;
      bits = code;
      chosen = bits[3] ? tx_in[{bits[1], bits[0]}] : 16'sd0;
      return chosen[15:2];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_sample(input string name, input usrp_pkg::sample_t expected,
                               input usrp_pkg::sample_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_dac(input string name, input usrp_pkg::dac_word_t expected,
                            input usrp_pkg::dac_word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %b, got %b", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_period(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("[ERROR] %s: expected %0d cycles, got %0d cycles", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_missing(input string name, input string sig, input int limit);
      $display("Test %s: no pulse on %s within %0d cycles", name, sig, limit);
      test_errors++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Drive and wait helpers

   task automatic drive_point();
      @(posedge clk64);
      #(DRIVE_DELAY_NS);
   endtask

   // Called at a drive point, returns at the next one
   task automatic write_reg(input usrp_pkg::serial_addr_t addr,
                            input usrp_pkg::serial_data_t data);
      serial_strobe = 1'b1;
      serial_addr = addr;
      serial_data = data;
      drive_point();
      serial_strobe = 1'b0;
   endtask

   // Counts falling edges up to and including the one that sees the pulse
   task automatic wait_pulse(input bit use_hb, input int limit,
                             output int cycles, output bit seen);
      seen = 1'b0;
      cycles = 0;
      while (!seen && cycles < limit) begin
         @(negedge clk64);
         cycles++;
         seen = use_hb ? hb_strobe : strobe_interp;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One table entry

   task automatic run_test(input test_entry_t t);
      int                      cycles;
      bit                      seen;
      bit                      use_hb;
      logic                    prev_sync;
      usrp_pkg::sample_t       exp_count;
      usrp_pkg::serial_data_t  data;
      test_errors = 0;
      drive_point();
      data = t.data;
      if (t.kind == CHK_DAC) begin
         data = random_mux_word();
      end else if (t.kind == CHK_LOOPBACK) begin
         tx_in[0] = random_sample();
         tx_in[1] = random_sample();
      end
      if (t.kind != CHK_RESET) begin
         write_reg(t.addr, data);
      end
      case (t.kind)
         CHK_RESET: begin
            repeat (t.expected) begin
               rx_i0 = random_sample();
               rx_q0 = random_sample();
               @(negedge clk64);
               check_dac(t.name, '0, tx_a);
               check_dac(t.name, '0, tx_b);
               check_bit(t.name, 1'b0, txsync);
               check_bit(t.name, 1'b0, strobe_interp);
               check_bit(t.name, 1'b0, hb_strobe);
               check_sample(t.name, rx_i0, rx_ch0);
               check_sample(t.name, rx_q0, rx_ch1);
               drive_point();
            end
         end
         CHK_TXSYNC: begin
            // Sync phase flips on every edge once TX runs
            @(negedge clk64);
            prev_sync = txsync;
            repeat (t.expected) begin
               @(negedge clk64);
               check_bit(t.name, ~prev_sync, txsync);
               prev_sync = txsync;
            end
         end
         CHK_DAC: begin
            repeat (t.expected) begin
               for (int k = 0; k < 4; k++) begin
                  tx_in[k] = random_sample();
               end
               @(negedge clk64);
               if (txsync) begin
                  check_dac(t.name, expected_dac(mux_model[1]), tx_a);
                  check_dac(t.name, expected_dac(mux_model[3]), tx_b);
               end else begin
                  check_dac(t.name, expected_dac(mux_model[0]), tx_a);
                  check_dac(t.name, expected_dac(mux_model[2]), tx_b);
               end
               drive_point();
            end
         end
         CHK_INTERP, CHK_DECIM: begin
            // First pulse after the write reloads the new rate
            use_hb = (t.kind == CHK_DECIM);
            wait_pulse(use_hb, t.budget, cycles, seen);
            if (seen) begin
               wait_pulse(use_hb, t.budget, cycles, seen);
            end
            if (seen) begin
               check_period(t.name, t.expected, cycles);
            end else begin
               report_missing(t.name, use_hb ? "o_hb_strobe" : "o_strobe_interp", t.budget);
            end
         end
         CHK_NO_HB: begin
            repeat (t.expected) begin
               @(negedge clk64);
               if (hb_strobe) begin
                  $display("Test %s: o_hb_strobe pulsed while RX is disabled", t.name);
                  test_errors++;
               end
            end
         end
         CHK_LOOPBACK: begin
            wait_pulse(1'b0, t.budget, cycles, seen);
            if (seen) begin
               @(negedge clk64);
               check_sample(t.name, tx_in[0], rx_ch0);
               check_sample(t.name, tx_in[1], rx_ch1);
            end else begin
               report_missing(t.name, "o_strobe_interp", t.budget);
            end
         end
         CHK_COUNT_IDLE: begin
            // Counter clears one edge after RX enable drops
            @(negedge clk64);
            @(negedge clk64);
            check_sample(t.name, 16'sd0, rx_ch0);
            check_sample(t.name, 16'sd1, rx_ch1);
         end
         CHK_COUNT_RUN: begin
            exp_count = 16'sd0;
            for (int p = 0; p < t.expected; p++) begin
               wait_pulse(1'b1, t.budget, cycles, seen);
               if (!seen) begin
                  report_missing(t.name, "o_hb_strobe", t.budget);
                  break;
               end
               check_sample(t.name, exp_count, rx_ch0);
               check_sample(t.name, exp_count + 16'sd1, rx_ch1);
               exp_count = exp_count + 16'sd2;
            end
         end
         default: ;
      endcase
      if (test_errors == 0) begin
         pass_count++;
         $display("PASS %s", t.name);
      end else begin
         fail_count++;
         $display("FAIL %s (%0d errors)", t.name, test_errors);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      serial_strobe = 1'b0;
      serial_addr = '0;
      serial_data = '0;
      for (int k = 0; k < 4; k++) begin
         tx_in[k] = 16'sd0;
      end
      rx_i0 = 16'sd0;
      rx_q0 = 16'sd0;
      pass_count = 0;
      fail_count = 0;
      build_table();
      table_ready = 1'b1;
      @(negedge rx_dsp_reset);
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(test_table[i]);
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, pass_count, fail_count);
      if (fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin : watchdog
      int total_cycles;
      wait (table_ready);
      total_cycles = RESET_CYCLES;
      for (int i = 0; i < NUM_TESTS; i++) begin
         total_cycles += test_table[i].budget;
      end
      #(total_cycles * TIMEOUT_FACTOR * CLK_PERIOD_NS);
      $display("Watchdog: run exceeded %0d clock cycles", total_cycles * TIMEOUT_FACTOR);
      $display("sim failed");
      $finish;
   end

endmodule

// File: project.f
verilog/usrp_pkg.sv
verilog/dsp_cfg_if.sv
verilog/strobe_gen.sv
verilog/master_control.sv
verilog/dac_mux.sv
verilog/rx_source_select.sv
verilog/usrp_dsp_top.sv
dv/tb_clock_gen.sv
dv/tb_usrp_dsp.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_usrp_dsp -f project.f

./obj_dir/Vtb_usrp_dsp | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

// File: verilog/dac_mux.sv
`timescale 1ns/1ps

module dac_mux (
   dsp_cfg_if.tx                cfg,
   input  usrp_pkg::sample_t    i_tx_i0,
   input  usrp_pkg::sample_t    i_tx_q0,
   input  usrp_pkg::sample_t    i_tx_i1,
   input  usrp_pkg::sample_t    i_tx_q1,
   output usrp_pkg::dac_word_t  o_tx_a,
   output usrp_pkg::dac_word_t  o_tx_b,
   output logic                 o_txsync
);

   usrp_pkg::sample_t slot [usrp_pkg::NUM_DAC];

   // Bit 2 of the code is don't-care
   function automatic usrp_pkg::sample_t pick_source(input usrp_pkg::dac_src_e sel,
                                                     input usrp_pkg::sample_t i0,
                                                     input usrp_pkg::sample_t q0,
                                                     input usrp_pkg::sample_t i1,
                                                     input usrp_pkg::sample_t q1);
      logic [3:0] code;
      code = sel;
      if (!code[3]) begin
         return '0;
      end
      if (code[1]) begin
         return code[0] ? q1 : i1;
      end
      return code[0] ? q0 : i0;
   endfunction

   always_comb begin
      for (int k = 0; k < usrp_pkg::NUM_DAC; k++) begin
         slot[k] = pick_source(cfg.dac_sel[k], i_tx_i0, i_tx_q0, i_tx_i1, i_tx_q1);
      end
   end

   // Odd slots on the high phase, even slots otherwise
   assign o_tx_a   = cfg.tx_sample_strobe ? slot[1][15:2] : slot[0][15:2];
   assign o_tx_b   = cfg.tx_sample_strobe ? slot[3][15:2] : slot[2][15:2];
   assign o_txsync = cfg.tx_sample_strobe;

endmodule

// File: verilog/dsp_cfg_if.sv
`timescale 1ns/1ps

// Configuration and timing strobes from control to the datapath
interface dsp_cfg_if;

   logic                enable_rx;
   usrp_pkg::dac_src_e  dac_sel [usrp_pkg::NUM_DAC];
   usrp_pkg::rx_src_e   rx_src;
   logic                tx_sample_strobe;
   logic                strobe_interp;
   logic                hb_strobe;

   modport ctrl (
      output enable_rx,
      output dac_sel,
      output rx_src,
      output tx_sample_strobe,
      output strobe_interp,
      output hb_strobe
   );

   modport tx (
      input dac_sel,
      input tx_sample_strobe
   );

   modport rx (
      input enable_rx,
      input rx_src,
      input strobe_interp,
      input hb_strobe
   );

endinterface

// File: verilog/master_control.sv
`timescale 1ns/1ps

module master_control (
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,
   input  logic                    i_serial_strobe,
   input  usrp_pkg::serial_addr_t  i_serial_addr,
   input  usrp_pkg::serial_data_t  i_serial_data,
   dsp_cfg_if.ctrl                 cfg
);

   localparam int SEL_W = $bits(usrp_pkg::dac_src_e);

   logic                enable_tx;
   logic                enable_rx;
   usrp_pkg::rate_t     interp_rate;
   usrp_pkg::rate_t     decim_rate;
   usrp_pkg::dac_src_e  dac_sel_q [usrp_pkg::NUM_DAC];
   logic                mode_loopback;
   logic                mode_counter;
   logic                tx_phase;

   ////////////////////////////////////////////////////////////////////////////
   // Settings register decode

   always_ff @(posedge clk64) begin
      if (rx_dsp_reset) begin
         enable_tx     <= 1'b0;
         enable_rx     <= 1'b0;
         interp_rate   <= '0;
         decim_rate    <= '0;
         mode_loopback <= 1'b0;
         mode_counter  <= 1'b0;
         for (int k = 0; k < usrp_pkg::NUM_DAC; k++) begin
            dac_sel_q[k] <= usrp_pkg::DAC_ZERO;
         end
      end else if (i_serial_strobe) begin
         case (i_serial_addr)
            usrp_pkg::FR_MASTER_CTRL: begin
               // Bit 0 TX enable, bit 1 RX enable
               enable_tx <= i_serial_data[0];
               enable_rx <= i_serial_data[1];
            end
            usrp_pkg::FR_INTERP_RATE: interp_rate <= i_serial_data[7:0];
            usrp_pkg::FR_DECIM_RATE:  decim_rate  <= i_serial_data[7:0];
            usrp_pkg::FR_MODE: begin
               mode_loopback <= i_serial_data[usrp_pkg::MODE_LOOPBACK_BIT];
               mode_counter  <= i_serial_data[usrp_pkg::MODE_COUNTER_BIT];
            end
            usrp_pkg::FR_TX_MUX: begin
               for (int k = 0; k < usrp_pkg::NUM_DAC; k++) begin
                  dac_sel_q[k] <= usrp_pkg::dac_src_e'(
                     i_serial_data[usrp_pkg::TX_MUX_DAC0_LSB + SEL_W*k +: SEL_W]);
               end
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // TX sync phase, alternates every cycle while TX runs

   always_ff @(posedge clk64) begin
      if (rx_dsp_reset || !enable_tx) begin
         tx_phase <= 1'b0;
      end else begin
         tx_phase <= ~tx_phase;
      end
   end

   assign cfg.tx_sample_strobe = tx_phase;
   assign cfg.enable_rx        = enable_rx;
   assign cfg.dac_sel          = dac_sel_q;

   // Counter mode has priority over loopback
   always_comb begin
      if (mode_counter) begin
         cfg.rx_src = usrp_pkg::RX_SRC_COUNTER;
      end else if (mode_loopback) begin
         cfg.rx_src = usrp_pkg::RX_SRC_LOOPBACK;
      end else begin
         cfg.rx_src = usrp_pkg::RX_SRC_ADC;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Rate strobes

   strobe_gen u_interp_strobe (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (enable_tx),
      .i_rate       (interp_rate),
      .i_strobe_in  (tx_phase),
      .o_strobe     (cfg.strobe_interp)
   );

   // RX has no sample strobe of its own, so every enabled cycle counts
   strobe_gen u_decim_strobe (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (enable_rx),
      .i_rate       (decim_rate),
      .i_strobe_in  (enable_rx),
      .o_strobe     (cfg.hb_strobe)
   );

endmodule

// File: verilog/rx_source_select.sv
`timescale 1ns/1ps

module rx_source_select (
   input  logic               clk64,
   input  logic               rx_dsp_reset,
   dsp_cfg_if.rx              cfg,
   input  usrp_pkg::sample_t  i_tx_i0,
   input  usrp_pkg::sample_t  i_tx_q0,
   input  usrp_pkg::sample_t  i_rx_i0,
   input  usrp_pkg::sample_t  i_rx_q0,
   output usrp_pkg::sample_t  o_rx_ch0,
   output usrp_pkg::sample_t  o_rx_ch1
);

   logic [15:0]        debug_counter;
   usrp_pkg::sample_t  loopback_i;
   usrp_pkg::sample_t  loopback_q;

   ////////////////////////////////////////////////////////////////////////////
   // Debug ramp, steps by two per output sample

   always_ff @(posedge clk64) begin
      if (rx_dsp_reset || !cfg.enable_rx) begin
         debug_counter <= 16'd0;
      end else if (cfg.hb_strobe) begin
         debug_counter <= debug_counter + 16'd2;
      end
   end

   // TX channel 0 snapshot at the interpolator rate
   always_ff @(posedge clk64) begin
      if (rx_dsp_reset) begin
         loopback_i <= '0;
         loopback_q <= '0;
      end else if (cfg.strobe_interp) begin
         loopback_i <= i_tx_i0;
         loopback_q <= i_tx_q0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Channel source choice

   always_comb begin
      case (cfg.rx_src)
         usrp_pkg::RX_SRC_COUNTER: begin
            // Channel 1 runs one ahead of channel 0
            o_rx_ch0 = usrp_pkg::sample_t'(debug_counter);
            o_rx_ch1 = usrp_pkg::sample_t'(debug_counter + 16'd1);
         end
         usrp_pkg::RX_SRC_LOOPBACK: begin
            o_rx_ch0 = loopback_i;
            o_rx_ch1 = loopback_q;
         end
         default: begin
            o_rx_ch0 = i_rx_i0;
            o_rx_ch1 = i_rx_q0;
         end
      endcase
   end

endmodule

// File: verilog/strobe_gen.sv
`timescale 1ns/1ps

module strobe_gen (
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             i_enable,
   input  usrp_pkg::rate_t  i_rate,
   input  logic             i_strobe_in,
   output logic             o_strobe
);

   usrp_pkg::rate_t count;

   // Down-counter over input strobes
   // Held at the rate while disabled so enabling starts a full period
   always_ff @(posedge clk64) begin
      if (rx_dsp_reset) begin
         count <= '0;
      end else if (!i_enable) begin
         count <= i_rate;
      end else if (i_strobe_in) begin
         if (count == '0) begin
            count <= i_rate;
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   // Fires on the input strobe that finds the count at zero
   assign o_strobe = i_enable && i_strobe_in && (count == '0);

endmodule

// File: verilog/usrp_dsp_top.sv
`timescale 1ns/1ps

module usrp_dsp_top (
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,

   // Settings bus
   input  logic                    i_serial_strobe,
   input  usrp_pkg::serial_addr_t  i_serial_addr,
   input  usrp_pkg::serial_data_t  i_serial_data,

   // Baseband samples
   input  usrp_pkg::sample_t       i_tx_i0,
   input  usrp_pkg::sample_t       i_tx_q0,
   input  usrp_pkg::sample_t       i_tx_i1,
   input  usrp_pkg::sample_t       i_tx_q1,
   input  usrp_pkg::sample_t       i_rx_i0,
   input  usrp_pkg::sample_t       i_rx_q0,

   // Converter side
   output usrp_pkg::dac_word_t     o_tx_a,
   output usrp_pkg::dac_word_t     o_tx_b,
   output logic                    o_txsync,

   // Rate strobes and RX channels
   output logic                    o_strobe_interp,
   output logic                    o_hb_strobe,
   output usrp_pkg::sample_t       o_rx_ch0,
   output usrp_pkg::sample_t       o_rx_ch1
);

   dsp_cfg_if cfg_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // Control

   master_control u_master_control (
      .clk64           (clk64),
      .rx_dsp_reset    (rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .cfg             (cfg_bus.ctrl)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Datapath

   dac_mux u_dac_mux (
      .cfg      (cfg_bus.tx),
      .i_tx_i0  (i_tx_i0),
      .i_tx_q0  (i_tx_q0),
      .i_tx_i1  (i_tx_i1),
      .i_tx_q1  (i_tx_q1),
      .o_tx_a   (o_tx_a),
      .o_tx_b   (o_tx_b),
      .o_txsync (o_txsync)
   );

   rx_source_select u_rx_source_select (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .cfg          (cfg_bus.rx),
      .i_tx_i0      (i_tx_i0),
      .i_tx_q0      (i_tx_q0),
      .i_rx_i0      (i_rx_i0),
      .i_rx_q0      (i_rx_q0),
      .o_rx_ch0     (o_rx_ch0),
      .o_rx_ch1     (o_rx_ch1)
   );

   // Strobes brought out for the chains outside this block
   assign o_strobe_interp = cfg_bus.strobe_interp;
   assign o_hb_strobe     = cfg_bus.hb_strobe;

endmodule

// File: verilog/usrp_pkg.sv
package usrp_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Word types

   typedef logic [6:0]         serial_addr_t;
   typedef logic [31:0]        serial_data_t;
   typedef logic signed [15:0] sample_t;
   // Upper 14 bits of a sample go to the converter
   typedef logic [13:0]        dac_word_t;
   typedef logic [7:0]         rate_t;

   localparam int NUM_DAC = 4;

   ////////////////////////////////////////////////////////////////////////////
   // Enumerations

   // DAC slot source codes
   // Bit 3 enables the slot, bit 1 picks the chain, bit 0 picks Q
   typedef enum logic [3:0] {
      DAC_ZERO = 4'd0,
      DAC_I0   = 4'd8,
      DAC_Q0   = 4'd9,
      DAC_I1   = 4'd10,
      DAC_Q1   = 4'd11
   } dac_src_e;

   // RX channel 0/1 source
   typedef enum logic [1:0] {
      RX_SRC_ADC      = 2'd0,
      RX_SRC_LOOPBACK = 2'd1,
      RX_SRC_COUNTER  = 2'd2
   } rx_src_e;

   ////////////////////////////////////////////////////////////////////////////
   // Settings register map

   localparam serial_addr_t FR_MASTER_CTRL = 7'd0;
   localparam serial_addr_t FR_INTERP_RATE = 7'd1;
   localparam serial_addr_t FR_DECIM_RATE  = 7'd2;
   localparam serial_addr_t FR_MODE        = 7'd3;
   localparam serial_addr_t FR_TX_MUX      = 7'd4;

   // Slot k field sits at TX_MUX_DAC0_LSB + 4k
   localparam int TX_MUX_DAC0_LSB   = 4;
   localparam int MODE_LOOPBACK_BIT = 0;
   localparam int MODE_COUNTER_BIT  = 1;

endpackage
